// ==== flist.f ====
+incdir+common
common/hypot_pkg.sv
hypot/square_sum.sv
hypot/isqrt_step.sv
hypot/magnitude_out.sv
source/hypot_top.sv
bench/hypot_assert.sv
bench/hypot_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the hypot testbench with Verilator.
# Pass or fail is read from the simulation log.

set -e

cd "$(dirname "$0")"

LOG=sim.log
BUILD_DIR=obj_dir

rm -rf "$BUILD_DIR" "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    --top-module hypot_tb \
    --Mdir "$BUILD_DIR" \
    -f flist.f

# tee keeps the log even when the run stops on an error
"./$BUILD_DIR/Vhypot_tb" 2>&1 | tee "$LOG" || true

if grep -q '\*\* PASS \*\*' "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

// ==== bench/hypot_tb.sv ====
`timescale 1ns/1ps

module hypot_tb;
    import hypot_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 4;
    localparam int N_FIXED    = 8;
    localparam int N_RANDOM   = 64;
    localparam int TAB_LEN    = N_FIXED + N_RANDOM;
    localparam int LATENCY    = 11;     // Enabled edges from capture to uo_out
    localparam int SEED       = 91045;
    localparam int WATCHDOG_NS = (TAB_LEN * 2 + 40) * CLK_PERIOD;

    logic       clk;
    logic       rst_n;
    logic       ena;
    logic [7:0] ui_in;
    logic [7:0] uio_in;
    logic [7:0] uo_out;
    logic [7:0] uio_out;
    logic [7:0] uio_oe;

    // Stimulus table, one row per cycle
    operand_t tab_x  [TAB_LEN];
    operand_t tab_y  [TAB_LEN];
    logic     tab_en [TAB_LEN];

    mag_t exp_q [$];        // Results still in flight
    mag_t exp_mag;
    logic exp_valid;
    int   n_en;             // Enabled edges since reset release
    int   popped;
    int   table_en_count;

    hypot_top DUT (
        .ui_in   (ui_in),
        .uio_in  (uio_in),
        .uo_out  (uo_out),
        .uio_out (uio_out),
        .uio_oe  (uio_oe),
        .ena     (ena),
        .clk     (clk),
        .rst_n   (rst_n)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_mag(input mag_t got, input mag_t exp, input string what);
        if (got !== exp) begin
            $display("Error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            stop_with_failure("Magnitude mismatch");
        end
    endtask

    task automatic check_valid(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
            stop_with_failure("Valid flag mismatch");
        end
    endtask

    // floor(sqrt(x*x + y*y)) by linear search, capped to the pin width
    function automatic mag_t ref_magnitude(input operand_t x, input operand_t y);
        int xi;
        int yi;
        int s;
        int r;
        xi = x;
        yi = y;
        s  = xi * xi + yi * yi;
        r  = 0;
        while ((r + 1) * (r + 1) <= s) begin
            r++;
        end
        if (r > 255) begin
            r = 255;
        end
        return mag_t'(r);
    endfunction

    task automatic add_row(input int idx, input operand_t x, input operand_t y, input logic en);
        tab_x[idx]  = x;
        tab_y[idx]  = y;
        tab_en[idx] = en;
    endtask

    task automatic build_table();
        add_row(0, 8'd0,   8'd0,   1'b1);
        add_row(1, 8'd3,   8'd4,   1'b1);   // Exact root
        add_row(2, 8'd255, 8'd0,   1'b1);
        add_row(3, 8'd0,   8'd255, 1'b1);
        add_row(4, 8'd180, 8'd180, 1'b1);   // Root 254, just under saturation
        add_row(5, 8'd200, 8'd200, 1'b1);   // Saturates
        add_row(6, 8'd255, 8'd255, 1'b1);
        add_row(7, 8'd1,   8'd1,   1'b1);
        for (int i = N_FIXED; i < TAB_LEN; i++) begin
            add_row(i, operand_t'($urandom % 256), operand_t'($urandom % 256),
                    ($urandom % 4) != 0);
        end
        table_en_count = 0;
        for (int i = 0; i < TAB_LEN; i++) begin
            if (tab_en[i]) begin
                table_en_count++;
            end
        end
    endtask

    // Drive one row on the falling edge, check the outputs one falling edge later
    task automatic run_cycle(input operand_t x, input operand_t y, input logic en);
        ui_in  = x;
        uio_in = y;
        ena    = en;
        if (en) begin
            exp_q.push_back(ref_magnitude(x, y));
        end
        @(negedge clk);
        if (en) begin
            n_en++;
        end
        exp_valid = (n_en >= LATENCY);
        if (en && exp_valid) begin
            exp_mag = exp_q.pop_front();
            popped++;
        end
        check_valid(uio_out[0], exp_valid, "uio_out[0]");
        check_mag(uo_out, exp_mag, "uo_out");
    endtask

    // Ends a run that stops making progress
    initial begin
        #(WATCHDOG_NS);
        stop_with_failure("Timeout: the run did not finish within the watchdog limit");
    end

    initial begin
        int n_drain;
        rst_n     = 1'b0;
        ena       = 1'b0;
        ui_in     = '0;
        uio_in    = '0;
        exp_mag   = '0;
        exp_valid = 1'b0;
        n_en      = 0;
        popped    = 0;
        n_drain   = 0;
        void'($urandom(SEED));
        build_table();

        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_mag(uo_out, '0, "uo_out after reset");
        check_valid(uio_out[0], 1'b0, "uio_out[0] after reset");

        for (int i = 0; i < TAB_LEN; i++) begin
            run_cycle(tab_x[i], tab_y[i], tab_en[i]);
        end

        // Push zeros until every table sample has come out
        while (popped < table_en_count && n_drain < 2 * LATENCY) begin
            run_cycle('0, '0, 1'b1);
            n_drain++;
        end
        ena = 1'b0;

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== bench/hypot_assert.sv ====
`timescale 1ns/1ps

module hypot_assert (
    input logic       clk,
    input logic       rst_n,
    input logic       ena,
    input logic [7:0] uo_out,
    input logic [7:0] uio_out,
    input logic [7:0] uio_oe
);

    // Only bit 0 of the bidirectional bank drives
    a_oe_const: assert property (@(posedge clk) uio_oe == 8'h01)
        else $error("uio_oe is not 0x01");

    a_uio_high_zero: assert property (@(posedge clk) uio_out[7:1] == 7'b0)
        else $error("uio_out[7:1] is not zero");

    // Frozen pipeline, outputs hold
    a_freeze: assert property (
        @(posedge clk) disable iff (!rst_n)
        !ena |=> ($stable(uo_out) && $stable(uio_out[0]))
    ) else $error("outputs changed across an edge with ena low");

    // Empty pipeline right after reset release
    a_reset_flag: assert property (@(posedge clk) $rose(rst_n) |=> !uio_out[0])
        else $error("valid flag high in the first cycle after reset");

endmodule

bind hypot_top hypot_assert u_hypot_assert (
    .clk     (clk),
    .rst_n   (rst_n),
    .ena     (ena),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
);

// ==== source/hypot_top.sv ====
`timescale 1ns/1ps
`include "hypot_cfg.svh"

module hypot_top (
    input  logic [7:0] ui_in,       // x operand
    input  logic [7:0] uio_in,      // y operand
    output logic [7:0] uo_out,      // floor(sqrt(x*x + y*y)), saturated
    output logic [7:0] uio_out,     // Bit 0 is the result-valid flag
    output logic [7:0] uio_oe,
    input  logic       ena,         // Advances the whole pipeline
    input  logic       clk,
    input  logic       rst_n
);
    import hypot_pkg::*;

    localparam int N_STAGES = `HYPOT_ROOT_W;

    // Index i feeds stage i, index N_STAGES is the loop output
    logic      stage_valid [0:N_STAGES];
    radicand_t stage_rem   [0:N_STAGES];
    radicand_t stage_rad   [0:N_STAGES];
    root_t     stage_root  [0:N_STAGES];

    logic      res_valid;

    // Squares, one enabled cycle
    square_sum u_square_sum (
        .clk   (clk),
        .rst_n (rst_n),
        .ena   (ena),
        .x     (ui_in),
        .y     (uio_in),
        .valid (stage_valid[0]),
        .rad   (stage_rad[0])
    );

    // Digit loop starts from an empty remainder and an empty root
    assign stage_rem[0]  = '0;
    assign stage_root[0] = '0;

    // One root bit per stage, MSB first
    for (genvar i = 0; i < N_STAGES; i++) begin : g_step
        isqrt_step u_step (
            .clk       (clk),
            .rst_n     (rst_n),
            .ena       (ena),
            .in_valid  (stage_valid[i]),
            .in_rem    (stage_rem[i]),
            .in_rad    (stage_rad[i]),
            .in_root   (stage_root[i]),
            .out_valid (stage_valid[i+1]),
            .out_rem   (stage_rem[i+1]),
            .out_rad   (stage_rad[i+1]),
            .out_root  (stage_root[i+1])
        );
    end

    // Saturate and drive the pins, one enabled cycle
    magnitude_out u_magnitude_out (
        .clk      (clk),
        .rst_n    (rst_n),
        .ena      (ena),
        .in_valid (stage_valid[N_STAGES]),
        .root     (stage_root[N_STAGES]),
        .valid    (res_valid),
        .mag      (uo_out)
    );

    // Only bit 0 of the bidirectional bank is an output
    assign uio_out = {7'b0, res_valid};
    assign uio_oe  = 8'h01;

endmodule

// ==== hypot/magnitude_out.sv ====
`timescale 1ns/1ps
`include "hypot_cfg.svh"

module magnitude_out (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             ena,
    input  logic             in_valid,
    input  hypot_pkg::root_t root,
    output logic             valid,
    output hypot_pkg::mag_t  mag
);
    import hypot_pkg::*;

    logic over;
    mag_t mag_sat;

    // Roots of 256 and up only come from x*x + y*y >= 65536
    assign over    = |root[`HYPOT_ROOT_W-1:`HYPOT_OUT_W];
    assign mag_sat = over ? {`HYPOT_OUT_W{1'b1}} : root[`HYPOT_OUT_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
            mag   <= '0;
        end else if (ena) begin
            valid <= in_valid;
            // Pin value holds its last result while empty slots drain after reset
            if (in_valid) begin
                mag <= mag_sat;
            end
        end
    end

endmodule

// ==== hypot/isqrt_step.sv ====
`timescale 1ns/1ps
`include "hypot_cfg.svh"

module isqrt_step (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ena,
    input  logic                 in_valid,
    input  hypot_pkg::radicand_t in_rem,
    input  hypot_pkg::radicand_t in_rad,
    input  hypot_pkg::root_t     in_root,
    output logic                 out_valid,
    output hypot_pkg::radicand_t out_rem,
    output hypot_pkg::radicand_t out_rad,
    output hypot_pkg::root_t     out_root
);
    import hypot_pkg::*;

    radicand_t rem_sh;      // Remainder with the next bit pair brought down
    radicand_t trial;       // 4*root + 1
    logic      fits;
    radicand_t rem_next;
    root_t     root_next;
    radicand_t rad_next;

    // Bring down the top two radicand bits into the remainder.
    // The remainder never exceeds 2*root, so no bits are lost in the shift.
    assign rem_sh = {in_rem[`HYPOT_RAD_W-2:0], in_rad[`HYPOT_RAD_W -: 2]};

    assign trial = {in_root, 2'b01};    // Zero-extended to the radicand width

    assign fits = (rem_sh >= trial);

    // Restoring step: subtract only when the trial value fits
    assign rem_next = fits ? (rem_sh - trial) : rem_sh;

    // New root bit enters at the bottom.
    // The top bit is still zero here in every stage but the last one.
    assign root_next = {in_root[`HYPOT_ROOT_W-2:0], fits};

    // Consumed pair leaves at the top, so every stage reads the same bits
    assign rad_next = {in_rad[`HYPOT_RAD_W-2:0], 2'b00};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (ena) begin
            out_valid <= in_valid;
        end
    end

    // Datapath moves with ena only
    always_ff @(posedge clk) begin
        if (ena) begin
            out_rem  <= rem_next;
            out_rad  <= rad_next;
            out_root <= root_next;
        end
    end

endmodule

// ==== hypot/square_sum.sv ====
`timescale 1ns/1ps

module square_sum (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ena,
    input  hypot_pkg::operand_t  x,
    input  hypot_pkg::operand_t  y,
    output logic                 valid,
    output hypot_pkg::radicand_t rad
);
    import hypot_pkg::*;

    radicand_t x_sq;
    radicand_t y_sq;
    radicand_t sum_sq;

    // Operands widen to the radicand before the multiply
    assign x_sq   = x * x;
    assign y_sq   = y * y;
    assign sum_sq = x_sq + y_sq;    // Up to 130050, needs bit 16

    // Every sample taken while ena is high is a live sample
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (ena) begin
            valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ena) begin
            rad <= sum_sq;          // Top pair is {0, sum[16]}
        end
    end

endmodule

// ==== common/hypot_pkg.sv ====
`include "hypot_cfg.svh"

package hypot_pkg;

    // One input operand
    typedef logic [`HYPOT_IN_W-1:0] operand_t;

    // Sum of squares and the running remainder.
    // Carries one zero bit above the 17-bit sum so the radicand splits
    // into nine whole bit pairs, one pair per digit stage.
    typedef logic [`HYPOT_RAD_W:0] radicand_t;

    // Partial root inside the loop, final root at its end
    typedef logic [`HYPOT_ROOT_W-1:0] root_t;

    // Saturated magnitude as driven on the output pins
    typedef logic [`HYPOT_OUT_W-1:0] mag_t;

endpackage

// ==== common/hypot_cfg.svh ====
`ifndef HYPOT_CFG_SVH
`define HYPOT_CFG_SVH

// Width of each unsigned operand, x on ui_in and y on uio_in
`define HYPOT_IN_W   8

// Full width of x*x + y*y, no wrap at 16 bits
`define HYPOT_RAD_W  17

// Root width. One root bit per digit stage, so this is also the stage count
`define HYPOT_ROOT_W 9

// Result width on uo_out after saturation
`define HYPOT_OUT_W  8

`endif
